//--- common/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;

    // standard LC-3b opcode encodings.
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef logic [2:0] lc3b_nzp; // n in bit 2, z in bit 1, p in bit 0.

    // a branch reads bits 11:9 as the nzp mask.
    typedef struct packed {
        lc3b_opcode  opcode;
        lc3b_nzp     nzp;
        logic [8:0]  offset;
    } lc3b_br_view;

    // a shift reads bit 5 as arithmetic and bit 4 as right.
    typedef struct packed {
        lc3b_opcode  opcode;
        logic [2:0]  dr;
        logic [2:0]  sr;
        logic        a;
        logic        d;
        logic [3:0]  imm4;
    } lc3b_shf_view;

    // one instruction word with two field layouts over the same bits.
    typedef union packed {
        lc3b_br_view  br;
        lc3b_shf_view shf;
    } lc3b_instr;

endpackage

`default_nettype wire

//--- compile.f
common/lc3b_pkg.sv
mem_stage/mem_access_ctrl.sv
mem_stage/mem_data_path.sv
source/cc_branch_unit.sv
source/perf_counters.sv
source/mem_stage_top.sv
sim/mem_stage_assert.sv
sim/mem_stage_tb.sv

//--- mem_stage/mem_access_ctrl.sv
`default_nettype none

module mem_access_ctrl (
    input  wire logic              clk,
    input  wire logic              br_count_reset,
    input  wire logic              instr_valid,
    input  wire lc3b_pkg::lc3b_instr instruction,
    input  wire logic              mem_resp,
    input  wire logic              addr_lsb,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic [1:0]             mem_wmask,
    output logic                   stall,
    output logic                   done,
    output logic                   indirect_phase
);

    import lc3b_pkg::*;

    logic acc_read;      // access kind decoded from the opcode.
    logic acc_write;
    logic acc_byte;
    logic acc_ind;
    logic mem_op;
    logic final_access;

    always_comb begin
        acc_read  = 1'b0;
        acc_write = 1'b0;
        acc_byte  = 1'b0;
        acc_ind   = 1'b0;
        case (instruction.br.opcode)
            op_ldr: acc_read = 1'b1;
            op_ldb: begin
                acc_read = 1'b1;
                acc_byte = 1'b1;
            end
            op_str: acc_write = 1'b1;
            op_stb: begin
                acc_write = 1'b1;
                acc_byte  = 1'b1;
            end
            // the pointer fetch is a read, the second access depends on the phase.
            op_ldi: begin
                acc_read = 1'b1;
                acc_ind  = 1'b1;
            end
            op_sti: begin
                acc_read  = ~indirect_phase;
                acc_write = indirect_phase;
                acc_ind   = 1'b1;
            end
            default: ;
        endcase
    end

    assign mem_op       = instr_valid & (acc_read | acc_write);
    assign final_access = mem_op & (~acc_ind | indirect_phase);

    assign mem_read  = instr_valid & acc_read;
    assign mem_write = instr_valid & acc_write;

    // byte stores enable only the lane picked by the low address bit.
    assign mem_wmask = (acc_write & acc_byte) ? (addr_lsb ? 2'b10 : 2'b01) : 2'b11;

    assign stall = mem_op & ~(final_access & mem_resp);
    assign done  = instr_valid & (~mem_op | (final_access & mem_resp));

    // sets on the pointer response and clears on the final response.
    always_ff @(posedge clk) begin
        if (br_count_reset) begin
            indirect_phase <= 1'b0;
        end else if (instr_valid && acc_ind && mem_resp) begin
            indirect_phase <= ~indirect_phase;
        end
    end

endmodule

`default_nettype wire

//--- mem_stage/mem_data_path.sv
`default_nettype none

module mem_data_path (
    input  wire logic                clk,
    input  wire logic                br_count_reset,
    input  wire lc3b_pkg::lc3b_instr instruction,
    input  wire logic                indirect_phase,
    input  wire logic                mem_resp,
    input  wire lc3b_pkg::lc3b_word  alu_out,
    input  wire lc3b_pkg::lc3b_word  pc_out,
    input  wire lc3b_pkg::lc3b_word  br_add_out,
    input  wire lc3b_pkg::lc3b_word  sr1_out,
    input  wire lc3b_pkg::lc3b_word  sr2_out,
    input  wire lc3b_pkg::lc3b_word  mem_rdata,
    output lc3b_pkg::lc3b_word       mem_address,
    output logic                     addr_lsb,
    output lc3b_pkg::lc3b_word       mem_wdata,
    output lc3b_pkg::lc3b_word       regfile_data
);

    import lc3b_pkg::*;

    lc3b_opcode opcode;
    lc3b_word   indirect_addr;
    lc3b_word   shift_out;
    logic [7:0] load_byte;
    logic       is_ind;

    assign opcode = instruction.br.opcode;
    assign is_ind = (opcode == op_ldi) || (opcode == op_sti);

    // captures the pointer returned by the first LDI or STI read.
    always_ff @(posedge clk) begin
        if (br_count_reset) begin
            indirect_addr <= '0;
        end else if (mem_resp && is_ind && !indirect_phase) begin
            indirect_addr <= mem_rdata;
        end
    end

    assign mem_address = indirect_phase ? indirect_addr : alu_out;
    assign addr_lsb    = mem_address[0];

    always_comb begin
        if (opcode == op_stb) begin
            mem_wdata = addr_lsb ? {sr2_out[7:0], 8'h00} : {8'h00, sr2_out[7:0]};
        end else begin
            mem_wdata = sr2_out;
        end
    end

    assign load_byte = addr_lsb ? mem_rdata[15:8] : mem_rdata[7:0];

    always_comb begin
        if (!instruction.shf.d) begin
            shift_out = sr1_out << instruction.shf.imm4;
        end else if (!instruction.shf.a) begin
            shift_out = sr1_out >> instruction.shf.imm4;
        end else begin
            shift_out = $signed(sr1_out) >>> instruction.shf.imm4; // sign fills from the top.
        end
    end

    always_comb begin
        case (opcode)
            op_add, op_and, op_not: regfile_data = alu_out;
            op_ldr, op_ldi:         regfile_data = mem_rdata;
            op_ldb:                 regfile_data = {8'h00, load_byte};
            op_lea:                 regfile_data = br_add_out;
            op_jsr:                 regfile_data = pc_out; // link value for R7.
            op_shf:                 regfile_data = shift_out;
            default:                regfile_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- sim/mem_stage_assert.sv
`default_nettype none

module mem_stage_assert #(
    parameter int cnt_width = 16
) (
    input wire logic                 clk,
    input wire logic                 br_count_reset,
    input wire logic                 instr_valid,
    input wire logic                 load_cc,
    input wire lc3b_pkg::lc3b_instr  instruction,
    input wire lc3b_pkg::lc3b_word   alu_out, pc_out, br_add_out, sr1_out, sr2_out,
    input wire logic                 mem_read, mem_write, mem_resp,
    input wire logic [1:0]           mem_wmask,
    input wire lc3b_pkg::lc3b_word   mem_address, mem_wdata, mem_rdata, regfile_data,
    input wire logic                 br_en, stall, done,
    input wire logic                 br_clear, taken_clear, stall_clear,
    input wire logic [cnt_width-1:0] br_count, br_taken_count, stall_count
);

    timeunit 1ns;
    timeprecision 100ps;

    import lc3b_pkg::*;

    lc3b_opcode           op;
    logic                 is_ind;
    logic                 ptr_seen; // the pointer of the running LDI or STI is back.
    lc3b_word             ptr;
    lc3b_word             exp_addr;
    lc3b_word             rd_word;
    lc3b_word             exp_wb;
    logic [17:0]          exp_store;
    logic [1:0]           exp_rw;
    logic                 exp_stall;
    logic                 exp_done;
    logic                 exp_br_en;
    lc3b_nzp              cc;
    logic [cnt_width-1:0] n_br;
    logic [cnt_width-1:0] n_taken;
    logic [cnt_width-1:0] n_stall;
    int                   fail_count = 0;

    function automatic lc3b_word read_pattern(input lc3b_word addr);
        return {addr[11:0], addr[15:12]} ^ 16'h5a5a; // rotate left by 4.
    endfunction

    function automatic lc3b_word shift_result(input lc3b_word src, input lc3b_instr ins);
        logic [31:0] ext;
        ext = {{16{src[15] & ins.shf.a}}, src};
        if (!ins.shf.d) begin
            return src << ins.shf.imm4;
        end
        ext = ext >> ins.shf.imm4;
        return ext[15:0];
    endfunction

    assign op        = instruction.br.opcode;
    assign is_ind    = (op == op_ldi) || (op == op_sti);
    assign exp_addr  = (is_ind && ptr_seen) ? ptr : alu_out;
    assign rd_word   = read_pattern(exp_addr);
    assign exp_stall = (exp_rw != 2'b00) && !(mem_resp && (!is_ind || ptr_seen));
    assign exp_done  = instr_valid && !exp_stall;
    assign exp_br_en = instr_valid && (op == op_br) && ((cc & instruction.br.nzp) != 3'b000);

    // mask in the top two bits, write data below.
    assign exp_store = (op == op_stb)
        ? {2'b01 << exp_addr[0], lc3b_word'(sr2_out[7:0]) << {exp_addr[0], 3'b000}}
        : {2'b11, sr2_out};

    always_comb begin
        case (op)
            op_ldr, op_ldb, op_ldi: exp_rw = 2'b10;
            op_str, op_stb:         exp_rw = 2'b01;
            op_sti:                 exp_rw = ptr_seen ? 2'b01 : 2'b10;
            default:                exp_rw = 2'b00;
        endcase
        if (!instr_valid) begin
            exp_rw = 2'b00;
        end
    end

    always_comb begin
        case (op)
            op_add, op_and, op_not: exp_wb = alu_out;
            op_ldr, op_ldi:         exp_wb = rd_word;
            op_ldb:                 exp_wb = exp_addr[0] ? (rd_word >> 8) : (rd_word & 16'h00ff);
            op_lea:                 exp_wb = br_add_out;
            op_jsr:                 exp_wb = pc_out;
            op_shf:                 exp_wb = shift_result(sr1_out, instruction);
            default:                exp_wb = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (br_count_reset) begin
            ptr_seen <= 1'b0;
            ptr      <= '0;
            cc       <= 3'b010;
            n_br     <= '0;
            n_taken  <= '0;
            n_stall  <= '0;
        end else begin
            if (instr_valid && is_ind && mem_resp && !ptr_seen) begin
                ptr_seen <= 1'b1;
                ptr      <= mem_rdata;
            end else if (exp_done) begin
                ptr_seen <= 1'b0;
            end
            if (exp_done && load_cc) begin
                cc <= (regfile_data == '0) ? 3'b010 : (regfile_data[15] ? 3'b100 : 3'b001);
            end
            n_br    <= br_clear ? '0 : n_br + cnt_width'(exp_done && op == op_br);
            n_taken <= taken_clear ? '0 : n_taken + cnt_width'(exp_done && exp_br_en);
            n_stall <= stall_clear ? '0 : n_stall + cnt_width'(exp_stall);
        end
    end

    a_handshake: assert property (@(posedge clk) disable iff (br_count_reset)
        {mem_read, mem_write, stall, done} == {exp_rw, exp_stall, exp_done})
    else begin
        fail_count++;
        $error("ERR handshake expected %b actual %b",
               $sampled({exp_rw, exp_stall, exp_done}), $sampled({mem_read, mem_write, stall, done}));
    end

    a_address: assert property (@(posedge clk) disable iff (br_count_reset)
        (exp_rw != 2'b00) |-> mem_address == exp_addr)
    else begin
        fail_count++;
        $error("ERR address expected %h actual %h", $sampled(exp_addr), $sampled(mem_address));
    end

    a_store: assert property (@(posedge clk) disable iff (br_count_reset)
        mem_write |-> {mem_wmask, mem_wdata} == exp_store)
    else begin
        fail_count++;
        $error("ERR store expected %h actual %h", $sampled(exp_store),
               $sampled({mem_wmask, mem_wdata}));
    end

    a_writeback: assert property (@(posedge clk) disable iff (br_count_reset)
        done |-> regfile_data == exp_wb)
    else begin
        fail_count++;
        $error("ERR writeback expected %h actual %h", $sampled(exp_wb), $sampled(regfile_data));
    end

    a_branch: assert property (@(posedge clk) disable iff (br_count_reset)
        br_en == exp_br_en)
    else begin
        fail_count++;
        $error("ERR branch expected %b actual %b", $sampled(exp_br_en), $sampled(br_en));
    end

    a_counters: assert property (@(posedge clk) disable iff (br_count_reset)
        {br_count, br_taken_count, stall_count} == {n_br, n_taken, n_stall})
    else begin
        fail_count++;
        $error("ERR counters expected %h actual %h", $sampled({n_br, n_taken, n_stall}),
               $sampled({br_count, br_taken_count, stall_count}));
    end

endmodule

bind mem_stage_top mem_stage_assert #(.cnt_width(cnt_width)) u_assert (.*);

`default_nettype wire

//--- sim/mem_stage_tb.sv
`default_nettype none

module mem_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import lc3b_pkg::*;

    localparam int cnt_width = 16;
    localparam int max_wait  = 32;

    logic                 clk;
    logic                 br_count_reset;
    logic                 instr_valid;
    lc3b_instr            instruction;
    lc3b_word             alu_out, pc_out, br_add_out, sr1_out, sr2_out;
    logic                 load_cc;
    logic                 mem_resp;
    lc3b_word             mem_rdata;
    logic                 br_clear, taken_clear, stall_clear;
    logic                 mem_read, mem_write;
    logic [1:0]           mem_wmask;
    lc3b_word             mem_address, mem_wdata, regfile_data;
    logic                 br_en, stall, done;
    logic [cnt_width-1:0] br_count, br_taken_count, stall_count;

    logic [31:0] rng = 32'hb63c_359d;
    int          mem_wait = 0;  // cycles left before the memory answers.
    lc3b_opcode  script [15] = '{op_ldr, op_ldb, op_str, op_stb, op_ldi, op_sti, op_add,
                                 op_and, op_not, op_lea, op_jsr, op_shf, op_br, op_br, op_rti};

    mem_stage_top #(.cnt_width(cnt_width)) dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic lc3b_word read_pattern(input lc3b_word addr);
        return {addr[11:0], addr[15:12]} ^ 16'h5a5a;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // the memory holds off each request for 0 to 3 cycles once the stimulus has settled.
    always @(posedge clk) begin
        #1.5;
        mem_resp = 1'b0;
        if (!br_count_reset && (mem_read || mem_write)) begin
            if (mem_wait == 0) begin
                mem_resp  = 1'b1;
                mem_rdata = read_pattern(mem_address);
                rng       = xorshift32(rng);
                mem_wait  = int'(rng[1:0]);
            end else begin
                mem_wait--;
            end
        end
    end

    always @(negedge clk) begin
        if (dut.u_assert.fail_count != 0) begin
            stop_with_failure("an assertion in the checker fired");
        end
    end

    task automatic present(input lc3b_opcode op);
        int cycles;
        rng         = xorshift32(rng);
        instruction = {op, rng[11:0]};
        rng         = xorshift32(rng);
        alu_out     = rng[15:0];
        sr1_out     = rng[31:16];
        rng         = xorshift32(rng);
        sr2_out     = rng[15:0];
        br_add_out  = rng[31:16];
        rng         = xorshift32(rng);
        pc_out      = rng[15:0];
        load_cc     = rng[16];
        br_clear    = (rng[22:20] == 3'd0);
        taken_clear = (rng[25:23] == 3'd0);
        stall_clear = (rng[28:26] == 3'd0);
        instr_valid = 1'b1;
        cycles      = 0;
        @(negedge clk);
        while (!done) begin
            cycles++;
            if (cycles > max_wait) begin
                stop_with_failure($sformatf("timeout: %s never finished, stall stayed high",
                                            op.name()));
            end
            @(posedge clk);
            #1;
            {br_clear, taken_clear, stall_clear} = 3'b000; // clears are one-cycle strobes.
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        {br_clear, taken_clear, stall_clear} = 3'b000;
    endtask

    task automatic idle_cycle();
        instr_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk            = 1'b0;
        br_count_reset = 1'b1;
        instr_valid    = 1'b0;
        instruction    = '0;
        alu_out        = '0;
        pc_out         = '0;
        br_add_out     = '0;
        sr1_out        = '0;
        sr2_out        = '0;
        load_cc        = 1'b0;
        mem_resp       = 1'b0;
        mem_rdata      = '0;
        br_clear       = 1'b0;
        taken_clear    = 1'b0;
        stall_clear    = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        br_count_reset = 1'b0;
        repeat (12) begin
            foreach (script[i]) begin
                present(script[i]);
                if (rng[31:29] == 3'd0) begin
                    idle_cycle();
                end
            end
        end
        repeat (2) @(posedge clk);
        if (dut.u_assert.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_with_failure("the checker counted failures");
        end
    end

endmodule

`default_nettype wire

//--- source/cc_branch_unit.sv
`default_nettype none

module cc_branch_unit (
    input  wire logic                clk,
    input  wire logic                br_count_reset,
    input  wire logic                instr_valid,
    input  wire lc3b_pkg::lc3b_instr instruction,
    input  wire logic                done,
    input  wire logic                load_cc,
    input  wire lc3b_pkg::lc3b_word  regfile_data,
    output logic                     br_en
);

    import lc3b_pkg::*;

    lc3b_nzp gen_cc;
    lc3b_nzp cc;

    // the result sets exactly one of n, z and p.
    always_comb begin
        gen_cc[2] = regfile_data[15];
        gen_cc[1] = (regfile_data == '0);
        gen_cc[0] = ~regfile_data[15] & (regfile_data != '0);
    end

    always_ff @(posedge clk) begin
        if (br_count_reset) begin
            cc <= 3'b010; // the codes come out of reset as zero.
        end else if (done && load_cc) begin
            cc <= gen_cc;
        end
    end

    assign br_en = instr_valid && (instruction.br.opcode == op_br)
                   && ((cc & instruction.br.nzp) != 3'b000);

endmodule

`default_nettype wire

//--- source/mem_stage_top.sv
`default_nettype none

module mem_stage_top #(
    parameter int cnt_width = 16
) (
    input  wire logic                clk,
    input  wire logic                br_count_reset,
    input  wire logic                instr_valid,
    input  wire lc3b_pkg::lc3b_instr instruction,
    input  wire lc3b_pkg::lc3b_word  alu_out,
    input  wire lc3b_pkg::lc3b_word  pc_out,
    input  wire lc3b_pkg::lc3b_word  br_add_out,
    input  wire lc3b_pkg::lc3b_word  sr1_out,
    input  wire lc3b_pkg::lc3b_word  sr2_out,
    input  wire logic                load_cc,
    input  wire logic                mem_resp,
    input  wire lc3b_pkg::lc3b_word  mem_rdata,
    input  wire logic                br_clear,
    input  wire logic                taken_clear,
    input  wire logic                stall_clear,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic [1:0]               mem_wmask,
    output lc3b_pkg::lc3b_word       mem_address,
    output lc3b_pkg::lc3b_word       mem_wdata,
    output lc3b_pkg::lc3b_word       regfile_data,
    output logic                     br_en,
    output logic                     stall,
    output logic                     done,
    output logic [cnt_width-1:0]     br_count,
    output logic [cnt_width-1:0]     br_taken_count,
    output logic [cnt_width-1:0]     stall_count
);

    logic indirect_phase;
    logic addr_lsb; // the address is chosen in the data path.

    mem_access_ctrl u_access_ctrl (
        .clk            (clk),
        .br_count_reset (br_count_reset),
        .instr_valid    (instr_valid),
        .instruction    (instruction),
        .mem_resp       (mem_resp),
        .addr_lsb       (addr_lsb),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_wmask      (mem_wmask),
        .stall          (stall),
        .done           (done),
        .indirect_phase (indirect_phase)
    );

    mem_data_path u_data_path (
        .clk            (clk),
        .br_count_reset (br_count_reset),
        .instruction    (instruction),
        .indirect_phase (indirect_phase),
        .mem_resp       (mem_resp),
        .alu_out        (alu_out),
        .pc_out         (pc_out),
        .br_add_out     (br_add_out),
        .sr1_out        (sr1_out),
        .sr2_out        (sr2_out),
        .mem_rdata      (mem_rdata),
        .mem_address    (mem_address),
        .addr_lsb       (addr_lsb),
        .mem_wdata      (mem_wdata),
        .regfile_data   (regfile_data)
    );

    cc_branch_unit u_cc_branch (
        .clk            (clk),
        .br_count_reset (br_count_reset),
        .instr_valid    (instr_valid),
        .instruction    (instruction),
        .done           (done),
        .load_cc        (load_cc),
        .regfile_data   (regfile_data),
        .br_en          (br_en)
    );

    perf_counters #(
        .cnt_width (cnt_width)
    ) u_perf_counters (
        .clk            (clk),
        .br_count_reset (br_count_reset),
        .instruction    (instruction),
        .done           (done),
        .br_en          (br_en),
        .stall          (stall),
        .br_clear       (br_clear),
        .taken_clear    (taken_clear),
        .stall_clear    (stall_clear),
        .br_count       (br_count),
        .br_taken_count (br_taken_count),
        .stall_count    (stall_count)
    );

endmodule

`default_nettype wire

//--- source/perf_counters.sv
`default_nettype none

module perf_counters #(
    parameter int cnt_width = 16
) (
    input  wire logic                clk,
    input  wire logic                br_count_reset,
    input  wire lc3b_pkg::lc3b_instr instruction,
    input  wire logic                done,
    input  wire logic                br_en,
    input  wire logic                stall,
    input  wire logic                br_clear,
    input  wire logic                taken_clear,
    input  wire logic                stall_clear,
    output logic [cnt_width-1:0]     br_count,
    output logic [cnt_width-1:0]     br_taken_count,
    output logic [cnt_width-1:0]     stall_count
);

    import lc3b_pkg::*;

    logic br_event;

    // a clear beats an increment in the same cycle.
    function automatic logic [cnt_width-1:0] next_count(
        input logic [cnt_width-1:0] cur,
        input logic                 clr,
        input logic                 inc
    );
        if (clr) begin
            return '0;
        end
        return inc ? cur + 1'b1 : cur; // wraps at the top.
    endfunction

    assign br_event = done && (instruction.br.opcode == op_br);

    always_ff @(posedge clk) begin
        if (br_count_reset) begin
            br_count       <= '0;
            br_taken_count <= '0;
            stall_count    <= '0;
        end else begin
            br_count       <= next_count(br_count, br_clear, br_event);
            br_taken_count <= next_count(br_taken_count, taken_clear, done && br_en);
            stall_count    <= next_count(stall_count, stall_clear, stall);
        end
    end

endmodule

`default_nettype wire
